// ==== filelist.f ====
rtl/md_cart_pkg.sv
rtl/rom_word_if.sv
rtl/rom_word_splitter.sv
rtl/rom_word_fifo.sv
rtl/cart_header_parser.sv
rtl/core_settings_regs.sv
rtl/md_cart_top.sv
tb/md_cart_assertions.sv
tb/md_cart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cartridge ROM path testbench under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module md_cart_tb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vmd_cart_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

// ==== tb/md_cart_tb.sv ====
/*
 * cartridge ROM path testbench
 * downloads small headers over the bridge and checks region,
 * title quirks, settings defaults and the bridge read mux
 */

module md_cart_tb import md_cart_pkg::*; ();

	localparam int poll_limit = 2000;
	localparam logic [31:0] rom_base = 32'h1000_0000; // ROM window, tag 1

	// settings in settings_vec order, msb first
	localparam logic [31:0] set_addr [10] = '{
		addr_cpu_turbo, addr_audio_filter, addr_fm_chip, addr_multitap, addr_ar_correct,
		addr_composite, addr_obj_limit, addr_fm_en, addr_psg_en, addr_hifi_pcm
	};
	localparam int set_pos [10] = '{10, 8, 7, 6, 5, 4, 3, 2, 1, 0};

	// reads that must come back zero
	localparam logic [31:0] zero_addr [5] = '{
		addr_multitap, addr_cpu_turbo, addr_region_reg + 32'd4,
		rom_base | 32'h1F0, 32'hFFFF_FFFC
	};

	logic        clk_74a;
	logic        pll_core_locked;
	logic        cart_download;
	logic [31:0] bridge_addr;
	logic        bridge_wr;
	logic [31:0] bridge_wr_data;
	logic        bridge_rd;
	logic [31:0] bridge_rd_data;
	logic        sram_quirk;
	logic        eeprom_quirk;
	logic        svp_quirk;
	logic        fmbusy_quirk;
	logic [1:0]  cpu_turbo;
	logic [1:0]  audio_filter;
	logic        fm_chip;
	logic        multitap_en;
	logic        ar_correct_en;
	logic        composite_en;
	logic        obj_limit_high_en;
	logic        fm_en;
	logic        psg_en;
	logic        hifi_pcm_en;

	logic [7:0] rom_img [0:515]; // header image, byte per address
	int         checks;
	int         errors;

	md_cart_top i_md_cart_top (.*);

	bind rom_word_fifo md_cart_assertions i_fifo_checks (
		.clk_74a         (clk_74a),
		.pll_core_locked (pll_core_locked),
		.push            (push),
		.pop             (pop),
		.count           (count),
		.out_addr        (out_words.addr)
	);

	always #50 clk_74a = ~clk_74a;

	//////////////////////////////////////////////////
	// helpers

	function automatic logic [3:0] quirk_vec();
		return {sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk};
	endfunction

	function automatic logic [11:0] settings_vec();
		return {cpu_turbo, audio_filter, fm_chip, multitap_en, ar_correct_en,
			composite_en, obj_limit_high_en, fm_en, psg_en, hifi_pcm_en};
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_74a);
		#10;
		bridge_addr    = addr;
		bridge_wr_data = data;
		bridge_wr      = 1'b1;
		@(posedge clk_74a);
		#10 bridge_wr = 1'b0; // one idle cycle before the next write
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk_74a);
		#10;
		bridge_addr = addr;
		bridge_rd   = 1'b1;
		@(negedge clk_74a);
		data = bridge_rd_data;
		@(posedge clk_74a);
		#10 bridge_rd = 1'b0;
	endtask

	task automatic clear_image();
		logic [9:0] idx;
		for (idx = 10'd0; idx < 10'd516; idx++)
			rom_img[idx] = 8'h00;
	endtask

	task automatic put_text(input logic [9:0] addr, input string text);
		int i;
		for (i = 0; i < text.len(); i++)
			rom_img[addr + i[9:0]] = text[i];
	endtask

	task automatic start_download();
		@(posedge clk_74a);
		#10 cart_download = 1'b1;
	endtask

	task automatic send_image();
		logic [9:0]  idx;
		logic [31:0] data;
		for (idx = 10'd0; idx <= 10'h200; idx += 10'd4) begin
			data = {rom_img[idx], rom_img[idx + 10'd1], rom_img[idx + 10'd2],
				rom_img[idx + 10'd3]}; // even byte in the top lane
			bridge_write(rom_base | {22'd0, idx}, data);
		end
	endtask

	// wait for the end word to reach the parser, then close the download
	task automatic finish_download();
		int n;
		n = 0;
		while (!i_md_cart_top.i_parser.hdr_ready && n < poll_limit) begin
			@(negedge clk_74a);
			n++;
		end
		if (!i_md_cart_top.i_parser.hdr_ready) begin
			errors++;
			$display("ERROR t=%0t header end word never reached the parser", $time);
		end
		@(posedge clk_74a);
		#10 cart_download = 1'b0;
	endtask

	task automatic download_image();
		start_download();
		send_image();
		finish_download();
	endtask

	task automatic wait_region(input logic [31:0] exp);
		logic [31:0] got;
		int          n;
		n = 0;
		read_reg(addr_region_reg, got);
		while (got !== exp && n < poll_limit) begin
			read_reg(addr_region_reg, got);
			n++;
		end
		expect_equal("bridge_rd_data (region)", got, exp);
	endtask

	task automatic wait_quirks(input logic [3:0] exp);
		logic [3:0] got;
		int         n;
		n = 0;
		@(negedge clk_74a);
		got = quirk_vec();
		while (got !== exp && n < poll_limit) begin
			@(negedge clk_74a);
			got = quirk_vec();
			n++;
		end
		expect_equal("{sram,eeprom,svp,fmbusy}_quirk", 32'(got), 32'(exp));
	endtask

	//////////////////////////////////////////////////
	// directed tests

	task automatic test_reset_state();
		logic [31:0] data;
		logic [11:0] exp;
		logic [11:0] field;
		logic [11:0] val;
		int          i;
		read_reg(addr_region_reg, data);
		expect_equal("bridge_rd_data (region)", data, 32'd0);
		expect_equal("{sram,eeprom,svp,fmbusy}_quirk", 32'(quirk_vec()), 32'd0);
		exp = 12'h00F; // obj limit, fm, psg, hifi pcm on
		expect_equal("settings", 32'(settings_vec()), 32'(exp));
		for (i = 0; i < 10; i++) begin
			field = (i < 2) ? 12'h3 : 12'h1;
			val   = (i < 2) ? 12'h3 : (((exp >> set_pos[i[3:0]]) & 12'h1) ^ 12'h1);
			bridge_write(set_addr[i[3:0]], 32'(val));
			exp = (exp & ~(field << set_pos[i[3:0]])) | (val << set_pos[i[3:0]]);
			expect_equal("settings", 32'(settings_vec()), 32'(exp));
		end
	endtask

	task automatic test_region_letters();
		clear_image();
		rom_img[10'h1F0] = "U"; // old style, letter in the high byte
		download_image();
		wait_region(32'd1);
		clear_image();
		rom_img[10'h1F3] = "E"; // second region word only
		download_image();
		wait_region(32'd2);
		clear_image();
		download_image();
		wait_region(32'd1); // no letters falls back to US
	endtask

	task automatic test_region_codes();
		clear_image();
		rom_img[10'h1F1] = "1"; // bit 0 only, JP
		download_image();
		wait_region(32'd0);
		clear_image();
		rom_img[10'h1F1] = "C"; // US and EU bits, US wins
		download_image();
		wait_region(32'd1);
	endtask

	task automatic test_title_quirks();
		clear_image();
		put_text(10'h183, "MK-1229 ");
		download_image();
		wait_quirks(4'b0010);
		clear_image();
		put_text(10'h183, "T-35036 ");
		download_image();
		wait_quirks(4'b0001);
	endtask

	task automatic test_quirk_clear();
		start_download();
		wait_quirks(4'b0000); // fmbusy from the last title must drop
		clear_image();
		put_text(10'h183, "T-99999 ");
		send_image();
		finish_download();
		wait_quirks(4'b0000);
		wait_region(32'd1);
	endtask

	task automatic test_read_zero();
		logic [31:0] data;
		int          i;
		for (i = 0; i < 5; i++) begin
			read_reg(zero_addr[i[2:0]], data);
			expect_equal("bridge_rd_data", data, 32'd0);
		end
	endtask

	//////////////////////////////////////////////////
	// sequence

	initial begin
		clk_74a         = 1'b0;
		pll_core_locked = 1'b0;
		cart_download   = 1'b0;
		bridge_addr     = 32'd0;
		bridge_wr       = 1'b0;
		bridge_wr_data  = 32'd0;
		bridge_rd       = 1'b0;
		checks          = 0;
		errors          = 0;
		repeat (16) @(posedge clk_74a);
		#10 pll_core_locked = 1'b1;

		test_reset_state();
		test_region_letters();
		test_region_codes();
		test_title_quirks();
		test_quirk_clear();
		test_read_zero();

		errors += i_md_cart_top.i_fifo.i_fifo_checks.fail_count;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		repeat (40000) @(posedge clk_74a);
		$display("ERROR run did not finish within 40000 cycles");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== tb/md_cart_assertions.sv ====
/*
 * queue checks bound into the ROM word FIFO
 * no overflow, no underflow, words leave in address order
 */

module md_cart_assertions import md_cart_pkg::*; (
	input logic                  clk_74a,
	input logic                  pll_core_locked,
	input logic                  push,
	input logic                  pop,
	input logic [fifo_cnt_w-1:0] count,
	input rom_addr_t             out_addr
);

	int fail_count = 0;
	int pushes; // words taken in since reset
	int pops;   // words handed out since reset

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			pushes <= 0;
			pops   <= 0;
		end else begin
			if (push)
				pushes <= pushes + 1;
			if (pop)
				pops <= pops + 1;
		end
	end

	no_overflow: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
		push |-> count != fifo_cnt_w'(fifo_depth))
		else begin
			$error("push into a full queue");
			fail_count++;
		end

	// every word handed out was taken in on an earlier cycle
	no_underflow: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
		pop |-> pops < pushes)
		else begin
			$error("pop from an empty queue");
			fail_count++;
		end

	// back to back pops carry consecutive ROM words
	in_order: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
		pop && $past(pop) |-> out_addr == $past(out_addr) + rom_addr_t'(2))
		else begin
			$error("words left the queue out of address order");
			fail_count++;
		end

endmodule

// ==== rtl/md_cart_top.sv ====
/*
 * cartridge ROM path top level
 * bridge writes -> word splitter -> queue -> header parser,
 * alongside the bridge-written core settings
 */

module md_cart_top import md_cart_pkg::*; (
	input  logic        clk_74a,
	input  logic        pll_core_locked,
	input  logic        cart_download,
	input  logic [31:0] bridge_addr,
	input  logic        bridge_wr,
	input  logic [31:0] bridge_wr_data,
	input  logic        bridge_rd,      // reads are combinational, strobe not needed
	output logic [31:0] bridge_rd_data,
	output logic        sram_quirk,
	output logic        eeprom_quirk,
	output logic        svp_quirk,
	output logic        fmbusy_quirk,
	output logic [1:0]  cpu_turbo,
	output logic [1:0]  audio_filter,
	output logic        fm_chip,
	output logic        multitap_en,
	output logic        ar_correct_en,
	output logic        composite_en,
	output logic        obj_limit_high_en,
	output logic        fm_en,
	output logic        psg_en,
	output logic        hifi_pcm_en
);

	region_t region;

	rom_word_if split_words ();
	rom_word_if fifo_words ();

	rom_word_splitter i_splitter (
		.clk_74a         (clk_74a),
		.pll_core_locked (pll_core_locked),
		.bridge_addr     (bridge_addr),
		.bridge_wr       (bridge_wr),
		.bridge_wr_data  (bridge_wr_data),
		.words           (split_words.source)
	);

	rom_word_fifo i_fifo (
		.clk_74a         (clk_74a),
		.pll_core_locked (pll_core_locked),
		.in_words        (split_words.sink),
		.out_words       (fifo_words.source)
	);

	cart_header_parser i_parser (
		.clk_74a         (clk_74a),
		.pll_core_locked (pll_core_locked),
		.cart_download   (cart_download),
		.words           (fifo_words.sink),
		.region          (region),
		.hdr_ready       (),
		.sram_quirk      (sram_quirk),
		.eeprom_quirk    (eeprom_quirk),
		.svp_quirk       (svp_quirk),
		.fmbusy_quirk    (fmbusy_quirk)
	);

	core_settings_regs i_settings (
		.clk_74a           (clk_74a),
		.pll_core_locked   (pll_core_locked),
		.bridge_addr       (bridge_addr),
		.bridge_wr         (bridge_wr),
		.bridge_wr_data    (bridge_wr_data),
		.region            (region),
		.bridge_rd_data    (bridge_rd_data),
		.cpu_turbo         (cpu_turbo),
		.audio_filter      (audio_filter),
		.fm_chip           (fm_chip),
		.multitap_en       (multitap_en),
		.ar_correct_en     (ar_correct_en),
		.composite_en      (composite_en),
		.obj_limit_high_en (obj_limit_high_en),
		.fm_en             (fm_en),
		.psg_en            (psg_en),
		.hifi_pcm_en       (hifi_pcm_en)
	);

endmodule

// ==== rtl/core_settings_regs.sv ====
/*
 * core settings registers
 * option bits written by the host over the bridge,
 * plus the bridge read mux for the region register
 */

module core_settings_regs import md_cart_pkg::*; (
	input  logic        clk_74a,
	input  logic        pll_core_locked,
	input  logic [31:0] bridge_addr,
	input  logic        bridge_wr,
	input  logic [31:0] bridge_wr_data,
	input  region_t     region,
	output logic [31:0] bridge_rd_data,
	output logic [1:0]  cpu_turbo,
	output logic [1:0]  audio_filter,
	output logic        fm_chip,
	output logic        multitap_en,
	output logic        ar_correct_en,
	output logic        composite_en,
	output logic        obj_limit_high_en,
	output logic        fm_en,
	output logic        psg_en,
	output logic        hifi_pcm_en
);

	//////////////////////////////////////////////////
	// write side

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			cpu_turbo         <= 2'd0;
			audio_filter      <= 2'd0;
			fm_chip           <= 1'b0;
			multitap_en       <= 1'b0;
			ar_correct_en     <= 1'b0;
			composite_en      <= 1'b0;
			obj_limit_high_en <= 1'b1; // sprite limit lifted
			fm_en             <= 1'b1;
			psg_en            <= 1'b1;
			hifi_pcm_en       <= 1'b1;
		end else if (bridge_wr) begin
			case (bridge_addr)
				addr_cpu_turbo:    cpu_turbo         <= bridge_wr_data[1:0];
				addr_audio_filter: audio_filter      <= bridge_wr_data[1:0];
				addr_fm_chip:      fm_chip           <= bridge_wr_data[0];
				addr_multitap:     multitap_en       <= bridge_wr_data[0];
				addr_ar_correct:   ar_correct_en     <= bridge_wr_data[0];
				addr_composite:    composite_en      <= bridge_wr_data[0];
				addr_obj_limit:    obj_limit_high_en <= bridge_wr_data[0];
				addr_fm_en:        fm_en             <= bridge_wr_data[0];
				addr_psg_en:       psg_en            <= bridge_wr_data[0];
				addr_hifi_pcm:     hifi_pcm_en       <= bridge_wr_data[0];
				default:           fm_en             <= fm_en;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// read side, combinational from the address

	always_comb begin
		bridge_rd_data = 32'd0;
		if (bridge_addr == addr_region_reg)
			bridge_rd_data = {30'd0, region};
	end

endmodule

// ==== rtl/cart_header_parser.sv ====
/*
 * cartridge header parser
 * watches ROM words during download for the region letters and
 * the serial number, and raises region and per-title quirk flags
 */

module cart_header_parser import md_cart_pkg::*; (
	input  logic     clk_74a,
	input  logic     pll_core_locked,
	input  logic     cart_download,
	rom_word_if.sink words,
	output region_t  region,
	output logic     hdr_ready,
	output logic     sram_quirk,
	output logic     eeprom_quirk,
	output logic     svp_quirk,
	output logic     fmbusy_quirk
);

	logic        hdr_wr;
	logic        old_download;
	logic        old_ready;
	logic        hdr_j;
	logic        hdr_u;
	logic        hdr_e;
	logic [7:0]  hi_chr;
	logic [7:0]  lo_chr;
	logic [3:0]  hrgn;
	logic [63:0] cart_id;

	assign hdr_wr = words.valid && cart_download;
	assign hi_chr = words.data.bytes[1];
	assign lo_chr = words.data.bytes[0];
	assign hrgn   = words.data.bytes[0][3:0] - 4'd7; // hex letter as region bits

	//////////////////////////////////////////////////
	// serial number capture, bytes 183 to 18A

	always_ff @(posedge clk_74a) begin
		if (hdr_wr) begin
			case (words.addr)
				hdr_id_first:                  cart_id[63:56] <= lo_chr;
				hdr_id_first + rom_addr_t'(2): cart_id[55:40] <= words.data.word;
				hdr_id_first + rom_addr_t'(4): cart_id[39:24] <= words.data.word;
				hdr_id_first + rom_addr_t'(6): cart_id[23:8]  <= words.data.word;
				hdr_id_first + rom_addr_t'(8): cart_id[7:0]   <= hi_chr;
				default:                       cart_id        <= cart_id;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// region letters and quirks

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			old_download <= 1'b0;
			hdr_ready    <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= 4'b0000;
		end else begin
			old_download <= cart_download;

			// new download starts clean
			if (!old_download && cart_download) begin
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
				{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= 4'b0000;
			end
			if (old_download && !cart_download)
				hdr_ready <= 1'b0;

			if (hdr_wr) begin
				case (words.addr)
					hdr_region_word: begin
						if (lo_chr == "J") hdr_j <= 1'b1;
						else if (lo_chr == "U") hdr_u <= 1'b1;
						else if (lo_chr == "E") hdr_e <= 1'b1;
						else if (lo_chr >= "0" && lo_chr <= "9")
							{hdr_e, hdr_u, hdr_j} <= {lo_chr[3], lo_chr[2], lo_chr[0]};
						else if (lo_chr >= "A" && lo_chr <= "F")
							{hdr_e, hdr_u, hdr_j} <= {hrgn[3], hrgn[2], hrgn[0]};

						// old style headers put the letter first
						if (hi_chr == "J") hdr_j <= 1'b1;
						else if (hi_chr == "U") hdr_u <= 1'b1;
						else if (hi_chr == "E") hdr_e <= 1'b1;
					end
					hdr_region_word2: begin
						if (lo_chr == "J") hdr_j <= 1'b1;
						else if (lo_chr == "U") hdr_u <= 1'b1;
						else if (lo_chr == "E") hdr_e <= 1'b1;
					end
					hdr_id_check: begin // serial complete
						if (cart_id inside {id_sram_a, id_sram_b, id_sram_c})
							sram_quirk <= 1'b1;
						if (cart_id inside {id_eeprom_a, id_eeprom_b})
							eeprom_quirk <= 1'b1;
						if (cart_id inside {id_svp_a, id_svp_b})
							svp_quirk <= 1'b1;
						if (cart_id inside {id_fmbusy_a, id_fmbusy_b})
							fmbusy_quirk <= 1'b1;
					end
					hdr_end_word: hdr_ready <= 1'b1;
					default: hdr_ready <= hdr_ready;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// region pick, US wins over EU over JP

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			old_ready <= 1'b0;
			region    <= region_jp;
		end else begin
			old_ready <= hdr_ready;
			if (!old_ready && hdr_ready) begin
				if (hdr_u)      region <= region_us;
				else if (hdr_e) region <= region_eu;
				else if (hdr_j) region <= region_jp;
				else            region <= region_us; // no letters found
			end
		end
	end

endmodule

// ==== rtl/rom_word_fifo.sv ====
/*
 * ROM word queue
 * eight-entry circular buffer between splitter and parser,
 * drains one word per cycle while it holds any
 */

module rom_word_fifo import md_cart_pkg::*; (
	input  logic       clk_74a,
	input  logic       pll_core_locked,
	rom_word_if.sink   in_words,
	rom_word_if.source out_words
);

	rom_addr_t fifo_addr [fifo_depth];
	rom_word_u fifo_data [fifo_depth];

	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_cnt_w-1:0] count;
	logic                  push;
	logic                  pop;

	assign push = in_words.valid;
	assign pop  = (count != '0); // consumer never stalls

	// oldest entry always on the output
	assign out_words.valid = pop;
	assign out_words.addr  = fifo_addr[rd_ptr];
	assign out_words.data  = fifo_data[rd_ptr];

	always_ff @(posedge clk_74a) begin
		if (push) begin
			fifo_addr[wr_ptr] <= in_words.addr;
			fifo_data[wr_ptr] <= in_words.data;
		end
	end

	//////////////////////////////////////////////////
	// pointers and fill level

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at eight
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== rtl/rom_word_splitter.sv ====
/*
 * ROM word splitter
 * each 32-bit bridge write into the ROM window becomes two
 * 16-bit words, upper half first (big-endian bridge)
 */

module rom_word_splitter import md_cart_pkg::*; (
	input  logic        clk_74a,
	input  logic        pll_core_locked,
	input  logic [31:0] bridge_addr,
	input  logic        bridge_wr,
	input  logic [31:0] bridge_wr_data,
	rom_word_if.source  words
);

	logic      rom_wr;
	logic      lo_pending; // low half waiting one cycle
	rom_addr_t lo_addr;
	rom_word_u lo_data;

	assign rom_wr = bridge_wr && (bridge_addr[31:28] == rom_window_tag);

	//////////////////////////////////////////////////
	// strobes

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			words.valid <= 1'b0;
			lo_pending  <= 1'b0;
		end else begin
			words.valid <= rom_wr || lo_pending;
			lo_pending  <= rom_wr;
		end
	end

	//////////////////////////////////////////////////
	// payload

	always_ff @(posedge clk_74a) begin
		if (rom_wr) begin
			words.addr      <= bridge_addr[rom_addr_w-1:0];
			words.data.word <= bridge_wr_data[31:16];
			lo_addr         <= bridge_addr[rom_addr_w-1:0] + rom_addr_t'(2);
			lo_data.word    <= bridge_wr_data[15:0];
		end else if (lo_pending) begin
			words.addr <= lo_addr; // second half of the write
			words.data <= lo_data;
		end
	end

endmodule

// ==== rtl/rom_word_if.sv ====
/*
 * ROM word link
 * one 16-bit word with its byte address, qualified by a
 * single-cycle valid strobe; the sink takes every strobe
 */

interface rom_word_if import md_cart_pkg::*; ();

	logic      valid; // one cycle per word
	rom_addr_t addr;  // byte address of the high byte
	rom_word_u data;

	modport source (
		output valid,
		output addr,
		output data
	);

	modport sink (
		input valid,
		input addr,
		input data
	);

endinterface

// ==== rtl/md_cart_pkg.sv ====
/*
 * cartridge ROM path shared definitions
 * bus widths, bridge register map, header word offsets,
 * quirk title IDs and the two-view ROM word
 */

package md_cart_pkg;

	//////////////////////////////////////////////////
	// ROM words

	localparam int rom_addr_w = 25;

	typedef logic [rom_addr_w-1:0] rom_addr_t;

	// a ROM word is read whole or as two characters
	typedef union packed {
		logic [15:0]     word;
		logic [1:0][7:0] bytes; // [1] even address, [0] odd address
	} rom_word_u;

	localparam logic [3:0] rom_window_tag = 4'h1; // bridge_addr[31:28]

	localparam int fifo_depth = 8;
	localparam int fifo_ptr_w = 3;
	localparam int fifo_cnt_w = 4;

	//////////////////////////////////////////////////
	// bridge register map

	localparam logic [31:0] addr_region_reg   = 32'h00E0_0000;
	localparam logic [31:0] addr_multitap     = 32'h0000_0000;
	localparam logic [31:0] addr_ar_correct   = 32'h0000_0010;
	localparam logic [31:0] addr_composite    = 32'h0000_0020;
	localparam logic [31:0] addr_obj_limit    = 32'h0000_0030;
	localparam logic [31:0] addr_fm_en        = 32'h0000_0040;
	localparam logic [31:0] addr_psg_en       = 32'h0000_0050;
	localparam logic [31:0] addr_hifi_pcm     = 32'h0000_0060;
	localparam logic [31:0] addr_fm_chip      = 32'h00A0_0000;
	localparam logic [31:0] addr_cpu_turbo    = 32'h00C0_0000;
	localparam logic [31:0] addr_audio_filter = 32'h00F0_0000;

	//////////////////////////////////////////////////
	// cartridge header

	localparam rom_addr_t hdr_region_word  = 25'h1F0;
	localparam rom_addr_t hdr_region_word2 = 25'h1F2;
	localparam rom_addr_t hdr_end_word     = 25'h200;
	localparam rom_addr_t hdr_id_first     = 25'h182;
	localparam rom_addr_t hdr_id_check     = 25'h18C;

	typedef logic [1:0] region_t;

	localparam region_t region_jp = 2'd0;
	localparam region_t region_us = 2'd1;
	localparam region_t region_eu = 2'd2;

	// quirk titles by serial
	localparam logic [63:0] id_sram_a   = "T-081276"; // NFL QB club
	localparam logic [63:0] id_sram_b   = "T-81406 ";
	localparam logic [63:0] id_sram_c   = "T-081586";
	localparam logic [63:0] id_eeprom_a = "MK-1215 ";
	localparam logic [63:0] id_eeprom_b = "G-4060  ";
	localparam logic [63:0] id_svp_a    = "MK-1229 "; // virtua racing
	localparam logic [63:0] id_svp_b    = "G-7001  ";
	localparam logic [63:0] id_fmbusy_a = "T-35036 "; // hellfire
	localparam logic [63:0] id_fmbusy_b = "T-25073 ";

endpackage
